//--- include/execConfig_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Datapath width of the teaching processor
`define EXEC_DATA_W   16

// Shared register file size
`define EXEC_NUM_REGS 8

// Must cover EXEC_NUM_REGS
`define EXEC_REG_AW   3

`endif

//--- design/execPkg.sv
`include "execConfig_config.svh"

package execPkg;

   // One register value
   typedef logic [`EXEC_DATA_W-1:0] dataT;

   // Register index
   typedef logic [`EXEC_REG_AW-1:0] regAddrT;

   // Kept ALU opcodes in the processor's decode numbering
   typedef enum logic [4:0] {
      ADD  = 5'd0,
      SUB  = 5'd1,   // Rt - Rs
      OR   = 5'd2,
      AND  = 5'd3,
      ROL  = 5'd4,
      SLL  = 5'd5,
      ROR  = 5'd6,
      SRA  = 5'd7,
      BTR  = 5'd11,  // Bit reverse of Rs
      SEQ  = 5'd12,
      SLT  = 5'd13,
      SLE  = 5'd14,
      SCO  = 5'd15,  // Carry out of Rs + Rt
      BLTZ = 5'd18,
      LBI  = 5'd19,
      SLBI = 5'd20
   } aluOpT;

   // Marker for opcodes this cluster does not execute
   localparam dataT BAD_RESULT = 16'hBADA;

endpackage

//--- design/regPortIf.sv
`timescale 1ns/10ps

interface regPortIf;

   logic             req;
   logic             gnt;
   execPkg::regAddrT raddrA;   // Rs
   execPkg::regAddrT raddrB;   // Rt
   execPkg::dataT    rdataA;
   execPkg::dataT    rdataB;
   logic             we;
   execPkg::regAddrT waddr;
   execPkg::dataT    wdata;

   modport lane (output req, raddrA, raddrB, we, waddr, wdata,
                 input  gnt, rdataA, rdataB);

   modport arb  (input  req, raddrA, raddrB, we, waddr, wdata,
                 output gnt, rdataA, rdataB);

   modport file (input  req, raddrA, raddrB, we, waddr, wdata,
                 output gnt, rdataA, rdataB);

endinterface

//--- design/alu.sv
`timescale 1ns/10ps
`include "execConfig_config.svh"

module alu (
   input  execPkg::dataT  a,      // Rs
   input  execPkg::dataT  b,      // Rt or immediate
   input  execPkg::aluOpT op,
   input  logic           sign,   // Select signed overflow
   output execPkg::dataT  out,
   output logic           ofl,
   output logic           zero
);

   localparam int W  = `EXEC_DATA_W;
   localparam int SW = $clog2(W);

   logic           isSub;
   execPkg::dataT  opA;
   execPkg::dataT  opB;
   logic           cin;
   execPkg::dataT  sum;
   logic           carry;
   logic           oflSigned;
   logic [SW-1:0]  shAmt;
   logic [2*W-1:0] rotL;
   logic [2*W-1:0] rotR;
   execPkg::dataT  revA;

   // Subtract is Rt - Rs, so swap and invert Rs
   assign isSub = (op == execPkg::SUB);
   assign opA   = isSub ? b  : a;
   assign opB   = isSub ? ~a : b;
   assign cin   = isSub;

   assign {carry, sum} = {1'b0, opA} + {1'b0, opB} + {{W{1'b0}}, cin};

   // Like signs in, other sign out
   assign oflSigned = ( opA[W-1] &  opB[W-1] & ~sum[W-1]) |
                      (~opA[W-1] & ~opB[W-1] &  sum[W-1]);
   assign ofl       = sign ? oflSigned : carry;

   assign zero = (a == '0);   // Flag follows Rs, not the result

   // Rotates take one half of a doubled word
   assign shAmt = opB[SW-1:0];
   assign rotL  = {opA, opA} << shAmt;
   assign rotR  = {opA, opA} >> shAmt;

   always_comb begin
      for (int i = 0; i < W; i++) begin
         revA[i] = opA[W-1-i];
      end
   end

   always_comb begin
      case (op)
         execPkg::ADD,
         execPkg::SUB:  out = sum;
         execPkg::OR:   out = opA | opB;
         execPkg::AND:  out = opA & opB;
         execPkg::ROL:  out = rotL[2*W-1:W];
         execPkg::SLL:  out = opA << shAmt;
         execPkg::ROR:  out = rotR[W-1:0];
         execPkg::SRA:  out = $signed(opA) >>> shAmt;
         execPkg::BTR:  out = revA;
         execPkg::SEQ:  out = {{(W-1){1'b0}}, opA == opB};
         execPkg::SLT:  out = {{(W-1){1'b0}}, $signed(opA) < $signed(opB)};
         execPkg::SLE:  out = {{(W-1){1'b0}}, $signed(opA) <= $signed(opB)};
         execPkg::SCO:  out = {{(W-1){1'b0}}, carry};
         execPkg::BLTZ: out = {W{opA[W-1]}};   // Mask of all ones when Rs < 0
         execPkg::LBI:  out = opB;
         execPkg::SLBI: out = {opA[W/2-1:0], {(W/2){1'b0}}} | opB;
         default:       out = execPkg::BAD_RESULT;
      endcase
   end

endmodule

//--- design/regFile.sv
`timescale 1ns/10ps
`include "execConfig_config.svh"

module regFile (
   input logic    clk,
   input logic    rstN,
   regPortIf.file port
);

   execPkg::dataT regs [`EXEC_NUM_REGS];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < `EXEC_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (port.req && port.we) begin
         regs[port.waddr] <= port.wdata;
      end
   end

   // Reads see the old value in the write cycle
   assign port.rdataA = regs[port.raddrA];
   assign port.rdataB = regs[port.raddrB];

   // Single accessor behind the arbiter is always served
   assign port.gnt = port.req;

endmodule

//--- design/regArbiter.sv
`timescale 1ns/10ps

module regArbiter (
   input logic    clk,
   input logic    rstN,
   regPortIf.arb  lane0,
   regPortIf.arb  lane1,
   regPortIf.lane file
);

   logic lastGnt;   // Lane granted most recently
   logic grant0;
   logic grant1;

   // On a tie the lane not served last wins
   assign grant0 = lane0.req & (~lane1.req | lastGnt);
   assign grant1 = lane1.req & (~lane0.req | ~lastGnt);

   always_ff @(posedge clk) begin
      if (!rstN) begin
         lastGnt <= 1'b1;   // Lane 0 takes the first tie
      end else if (grant0) begin
         lastGnt <= 1'b0;
      end else if (grant1) begin
         lastGnt <= 1'b1;
      end
   end

   assign file.req    = grant0 | grant1;
   assign file.raddrA = grant1 ? lane1.raddrA : lane0.raddrA;
   assign file.raddrB = grant1 ? lane1.raddrB : lane0.raddrB;
   assign file.waddr  = grant1 ? lane1.waddr  : lane0.waddr;
   assign file.wdata  = grant1 ? lane1.wdata  : lane0.wdata;
   assign file.we     = (grant0 & lane0.we) | (grant1 & lane1.we);

   assign lane0.gnt = grant0 & file.gnt;
   assign lane1.gnt = grant1 & file.gnt;

   // Both lanes see the read data and only the granted one uses it
   assign lane0.rdataA = file.rdataA;
   assign lane0.rdataB = file.rdataB;
   assign lane1.rdataA = file.rdataA;
   assign lane1.rdataB = file.rdataB;

endmodule

//--- design/execLane.sv
`timescale 1ns/10ps

module execLane (
   input  logic             clk,
   input  logic             rstN,
   input  logic             issueValid,
   input  execPkg::aluOpT   op,
   input  execPkg::regAddrT rs,
   input  execPkg::regAddrT rt,
   input  execPkg::regAddrT rd,
   input  execPkg::dataT    imm,
   input  logic             useImm,
   input  logic             sign,
   output logic             busy,
   output logic             done,
   output execPkg::dataT    result,
   output logic             ofl,
   output logic             zero,
   regPortIf.lane           port
);

   execPkg::aluOpT   opQ;
   execPkg::regAddrT rsQ, rtQ, rdQ;
   execPkg::dataT    immQ;
   logic             useImmQ;
   logic             signQ;
   logic             req;
   logic             fire;      // Granted cycle
   execPkg::dataT    aluB;
   execPkg::dataT    aluOut;
   logic             aluOfl;
   logic             aluZero;

   assign fire = req & port.gnt;

   // Issue capture only while idle
   always_ff @(posedge clk) begin
      if (issueValid && !busy) begin
         opQ     <= op;
         rsQ     <= rs;
         rtQ     <= rt;
         rdQ     <= rd;
         immQ    <= imm;
         useImmQ <= useImm;
         signQ   <= sign;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         busy <= 1'b0;
         req  <= 1'b0;
         done <= 1'b0;
      end else begin
         done <= fire;
         if (fire) begin
            busy <= 1'b0;
            req  <= 1'b0;
         end else if (busy) begin
            req  <= 1'b1;   // One cycle after the issue edge
         end else if (issueValid) begin
            busy <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         result <= aluOut;
         ofl    <= aluOfl;
         zero   <= aluZero;
      end
   end

   assign port.req    = req;
   assign port.raddrA = rsQ;
   assign port.raddrB = rtQ;
   assign port.we     = fire;
   assign port.waddr  = rdQ;
   assign port.wdata  = aluOut;

   assign aluB = useImmQ ? immQ : port.rdataB;

   alu uAlu (
      .a    (port.rdataA),
      .b    (aluB),
      .op   (opQ),
      .sign (signQ),
      .out  (aluOut),
      .ofl  (aluOfl),
      .zero (aluZero)
   );

endmodule

//--- design/execCluster.sv
`timescale 1ns/10ps

module execCluster (
   input  logic                   clk,
   input  logic                   rstN,
   input  logic             [1:0] issueValid,
   input  execPkg::aluOpT   [1:0] op,
   input  execPkg::regAddrT [1:0] rs,
   input  execPkg::regAddrT [1:0] rt,
   input  execPkg::regAddrT [1:0] rd,
   input  execPkg::dataT    [1:0] imm,
   input  logic             [1:0] useImm,
   input  logic             [1:0] sign,    // Signed overflow per lane
   output logic             [1:0] busy,
   output logic             [1:0] done,
   output execPkg::dataT    [1:0] result,
   output logic             [1:0] ofl,
   output logic             [1:0] zero
);

   regPortIf lanePort [2] ();   // Lane to arbiter
   regPortIf filePort ();       // Arbiter to register file

   for (genvar i = 0; i < 2; i++) begin : gLane
      execLane uLane (
         .clk        (clk),
         .rstN       (rstN),
         .issueValid (issueValid[i]),
         .op         (op[i]),
         .rs         (rs[i]),
         .rt         (rt[i]),
         .rd         (rd[i]),
         .imm        (imm[i]),
         .useImm     (useImm[i]),
         .sign       (sign[i]),
         .busy       (busy[i]),
         .done       (done[i]),
         .result     (result[i]),
         .ofl        (ofl[i]),
         .zero       (zero[i]),
         .port       (lanePort[i])
      );
   end

   regArbiter uArb (
      .clk   (clk),
      .rstN  (rstN),
      .lane0 (lanePort[0]),
      .lane1 (lanePort[1]),
      .file  (filePort)
   );

   regFile uRegFile (
      .clk  (clk),
      .rstN (rstN),
      .port (filePort)
   );

endmodule

//--- verification/execClusterTb.sv
`timescale 1ns/10ps
`include "execConfig_config.svh"

module execClusterTb;

   logic                   clk;
   logic                   rstN;
   logic             [1:0] issueValid;
   execPkg::aluOpT   [1:0] op;
   execPkg::regAddrT [1:0] rs, rt, rd;
   execPkg::dataT    [1:0] imm;
   logic             [1:0] useImm, sign;
   logic             [1:0] busy, done, ofl, zero;
   execPkg::dataT    [1:0] result;

   execPkg::dataT    model [`EXEC_NUM_REGS];   // Expected register file contents
   execPkg::dataT    expRes [2];
   logic             expOfl [2], expZero [2], chkOfl [2];
   execPkg::regAddrT expRd [2];
   int               errors;
   int               failures;   // Timeouts and lost done pulses

   execCluster DUT (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Expected ALU output from the opcode rules
   function automatic execPkg::dataT refAlu(input execPkg::aluOpT o, input execPkg::dataT a, b,
                                            input logic sg, output logic ov);
      logic [16:0]   wide;
      int            n;
      execPkg::dataT r;
      n    = b[3:0];   // Shift amount
      wide = a + b;
      ov   = 1'b0;
      case (o)
         execPkg::ADD: begin
            r  = wide[15:0];
            ov = sg ? (a[15] == b[15] && r[15] != a[15]) : wide[16];
         end
         execPkg::SUB: begin
            r  = b - a;   // Rt minus Rs
            ov = sg ? (a[15] != b[15] && r[15] != b[15]) : (b >= a);
         end
         execPkg::OR:   r = a | b;
         execPkg::AND:  r = a & b;
         execPkg::ROL:  r = (a << n) | (a >> (16 - n));
         execPkg::SLL:  r = a << n;
         execPkg::ROR:  r = (a >> n) | (a << (16 - n));
         execPkg::SRA:  r = $signed(a) >>> n;
         execPkg::BTR:  for (int i = 0; i < 16; i++) r[i] = a[15-i];
         execPkg::SEQ:  r = (a == b);
         execPkg::SLT:  r = ($signed(a) < $signed(b));
         execPkg::SLE:  r = ($signed(a) <= $signed(b));
         execPkg::SCO:  r = wide[16];
         execPkg::BLTZ: r = a[15] ? 16'hFFFF : 16'h0000;
         execPkg::LBI:  r = b;
         execPkg::SLBI: r = (a << 8) | b;
         default:       r = 16'hBADA;
      endcase
      return r;
   endfunction

   task automatic checkVal(input string name, input logic [15:0] exp, act);
      if (exp !== act) begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   // Drives one lane with its issue strobe and records what it should return
   task automatic launch(input int ln, input execPkg::aluOpT o, input execPkg::regAddrT s, t, d,
                         input execPkg::dataT im, input logic ui, sg);
      execPkg::dataT a;
      execPkg::dataT b;
      a              = model[s];
      b              = ui ? im : model[t];
      op[ln]         = o;
      rs[ln]         = s;
      rt[ln]         = t;
      rd[ln]         = d;
      imm[ln]        = im;
      useImm[ln]     = ui;
      sign[ln]       = sg;
      issueValid[ln] = 1'b1;
      expRes[ln]     = refAlu(o, a, b, sg, expOfl[ln]);
      expZero[ln]    = (a == '0);
      expRd[ln]      = d;
      chkOfl[ln]     = (o == execPkg::ADD || o == execPkg::SUB);
   endtask

   // Called on the first falling edge after the issue edge
   task automatic waitDone(input int ln, output int cycles);
      cycles = 0;
      while (!done[ln] && cycles < 20) begin
         @(negedge clk);
         cycles++;
      end
      if (!done[ln]) begin
         $display("Timeout: lane %0d never signalled done", ln);
         failures++;
      end
   endtask

   task automatic checkLane(input int ln, input string name);
      checkVal(name, expRes[ln], result[ln]);
      checkVal({name, " zero"}, expZero[ln], zero[ln]);
      if (chkOfl[ln]) checkVal({name, " ofl"}, expOfl[ln], ofl[ln]);
      model[expRd[ln]] = expRes[ln];
   endtask

   task automatic issueOp(input int ln, input execPkg::aluOpT o, input execPkg::regAddrT s, t, d,
                          input execPkg::dataT im, input logic ui, sg, input string name);
      int lat;
      @(negedge clk);
      launch(ln, o, s, t, d, im, ui, sg);
      @(negedge clk);
      issueValid = '0;
      waitDone(ln, lat);
      if (done[ln]) checkLane(ln, name);
   endtask

   task automatic testArith();
      execPkg::aluOpT arith [4] = '{execPkg::ADD, execPkg::SUB, execPkg::OR, execPkg::AND};
      for (int r = 1; r < 8; r++) issueOp(0, execPkg::LBI, 0, 0, r, $urandom, 1, 0, "lbi");
      foreach (arith[i]) begin
         issueOp(0, arith[i], 1, 2, 3 + i, 0, 0, i % 2, $sformatf("arith %0d", i));
         issueOp(0, execPkg::ADD, 3 + i, 0, 7, 0, 1, 0, "readback");   // Read rd again
      end
   endtask

   task automatic testShift();
      execPkg::aluOpT shOps [4] = '{execPkg::ROL, execPkg::SLL, execPkg::ROR, execPkg::SRA};
      int             amts [5]  = '{0, 1, 7, 15, 19};   // 19 wraps to 3
      for (int v = 0; v < 3; v++) begin
         issueOp(0, execPkg::LBI, 0, 0, 1, (v == 0) ? ($urandom | 32'h8000) : $urandom,
                 1, 0, "lbi");
         foreach (shOps[i]) begin
            foreach (amts[j]) issueOp(0, shOps[i], 1, 0, 2, amts[j], 1, 0, "shift");
         end
         issueOp(0, execPkg::BTR, 1, 0, 3, 0, 1, 0, "btr");
         issueOp(0, execPkg::SLBI, 1, 0, 3, $urandom & 32'hFF, 1, 0, "slbi");
      end
   endtask

   task automatic testCompare();
      execPkg::dataT  bnd [5]    = '{16'h7FFF, 16'h8000, 16'hFFFF, 16'h0000, 16'h0001};
      execPkg::aluOpT cmpOps [5] = '{execPkg::SEQ, execPkg::SLT, execPkg::SLE, execPkg::SCO,
                                     execPkg::BLTZ};
      foreach (bnd[i]) issueOp(0, execPkg::LBI, 0, 0, i + 1, bnd[i], 1, 0, "lbi");
      foreach (bnd[i]) begin
         foreach (bnd[j]) begin
            foreach (cmpOps[k]) issueOp(0, cmpOps[k], i + 1, j + 1, 7, 0, 0, 0, "cmp");
            for (int s = 0; s < 2; s++) begin
               issueOp(0, execPkg::ADD, i + 1, j + 1, 7, 0, 0, s, "add corner");
               issueOp(0, execPkg::SUB, i + 1, j + 1, 7, 0, 0, s, "sub corner");
            end
         end
      end
      issueOp(0, execPkg::aluOpT'(5'd8), 1, 2, 7, 0, 0, 0, "unused op");
   endtask

   task automatic testTiming();
      int lat;
      @(negedge clk);
      launch(0, execPkg::ADD, 1, 2, 6, 0, 0, 0);
      @(negedge clk);
      issueValid = '0;
      checkVal("busy between", 1, busy[0]);
      waitDone(0, lat);
      checkVal("latency", 2, lat);
      checkVal("busy at done", 0, busy[0]);
      if (done[0]) checkLane(0, "timing");
      @(negedge clk);
      checkVal("done width", 0, done[0]);
   endtask

   // Both lanes issue together and first is the lane expected to win
   task automatic dualIssue(input int first, input string name);
      int lat;
      @(negedge clk);
      launch(0, execPkg::ADD, 1, 2, 6, 0, 0, 0);
      launch(1, execPkg::SUB, 3, 4, 7, 0, 0, 1);
      @(negedge clk);
      issueValid = '0;
      checkVal({name, " both busy"}, 2'b11, busy);
      waitDone(first, lat);
      checkVal({name, " winner latency"}, 2, lat);
      checkVal({name, " loser waits"}, 0, done[1-first]);
      if (done[first]) checkLane(first, name);
      waitDone(1 - first, lat);
      checkVal({name, " loser delay"}, 1, lat);
      if (done[1-first]) checkLane(1 - first, name);
   endtask

   task automatic testContention();
      issueOp(1, execPkg::OR, 1, 2, 3, 0, 0, 0, "lane 1 alone");   // Lane 1 served last
      dualIssue(0, "tie to lane 0");
      issueOp(1, execPkg::ADD, 7, 0, 4, 0, 1, 0, "hold r7");
      issueOp(0, execPkg::ADD, 6, 0, 5, 0, 1, 0, "hold r6");   // Now lane 0 served last
      dualIssue(1, "tie to lane 1");
   endtask

   task automatic testBackPressure();
      int lat;
      int count;
      @(negedge clk);
      launch(0, execPkg::ADD, 1, 2, 6, 0, 0, 0);
      @(negedge clk);
      op[0] = execPkg::SUB;   // Second offer while busy
      waitDone(0, lat);
      issueValid = '0;
      count      = done[0];
      if (done[0]) checkLane(0, "first op kept");
      repeat (6) begin
         @(negedge clk);
         count += done[0];
      end
      checkVal("done count", 1, count);
      issueOp(0, execPkg::ADD, 6, 0, 5, 0, 1, 0, "rd after busy issue");
   endtask

   initial begin
      void'($urandom(43));
      errors     = 0;
      failures   = 0;
      rstN       = 1'b0;
      issueValid = '0;
      op[0]      = execPkg::ADD;
      op[1]      = execPkg::ADD;
      rs         = '0;
      rt         = '0;
      rd         = '0;
      imm        = '0;
      useImm     = '0;
      sign       = '0;
      foreach (model[i]) model[i] = '0;
      repeat (8) @(negedge clk);
      rstN = 1'b1;
      testArith();
      testShift();
      testCompare();
      testTiming();
      testContention();
      testBackPressure();
      $display("Value errors: %0d, timeouts and lost done: %0d", errors, failures);
      if (errors == 0 && failures == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

//--- project.f
+incdir+include
design/execPkg.sv
design/regPortIf.sv
design/alu.sv
design/regFile.sv
design/regArbiter.sv
design/execLane.sv
design/execCluster.sv
verification/execClusterTb.sv

//--- Bender.yml
package:
  name: exec_cluster

sources:
  - include_dirs:
      - include
    files:
      - design/execPkg.sv
      - design/regPortIf.sv
      - design/alu.sv
      - design/regFile.sv
      - design/regArbiter.sv
      - design/execLane.sv
      - design/execCluster.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/execClusterTb.sv
